// File: hw/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Address split: tag | index | offset
`define CACHE_ADDR_BITS     32
`define CACHE_LINE_BITS     128  // 16 bytes
`define CACHE_OFFSET_BITS   4
`define CACHE_INDEX_BITS    4    // 16 sets
`define CACHE_TAG_BITS      24

// Configuration space
`define CACHE_CFG_ADDR_BITS 2
`define CACHE_CFG_WAY_EN    0    // Way-enable mask

`endif

// File: hw/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    localparam int CACHE_WAYS = 4;  // One-hot selects are built around four

    typedef logic [`CACHE_ADDR_BITS-1:0]   addr_t;
    typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;
    typedef logic [31:0]                   word_t;
    typedef logic [`CACHE_LINE_BITS-1:0]   line_t;
    typedef logic [CACHE_WAYS-1:0]         way_sel_t;

    typedef enum logic [2:0] {
        NO_OP = 3'd0,
        LD    = 3'd1,
        ST    = 3'd2,
        WR    = 3'd4
    } cache_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        ST_I = 2'd0,
        ST_S = 2'd1,
        ST_M = 2'd2
    } line_state_e;

    typedef struct packed {
        tag_t        tag;
        line_state_e state;
    } way_meta_t;

    typedef struct packed {
        logic         valid;
        cache_op_e    op;
        addr_t        addr;
        access_size_e size;
        word_t        wdata;
        line_t        fill_line;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        logic  hit;
        word_t rdata;
        word_t rewind_data;
    } cache_resp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;  // Line aligned
        line_t line;
    } evict_t;

endpackage

// File: hw/cache_cfg_regs.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_cfg_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_we,
    input  logic [`CACHE_CFG_ADDR_BITS-1:0] cfg_addr,
    input  cache_pkg::word_t                cfg_wdata,
    output cache_pkg::word_t                cfg_rdata,
    output cache_pkg::way_sel_t             way_en
);
    import cache_pkg::*;

    localparam logic [`CACHE_CFG_ADDR_BITS-1:0] WAY_EN_ADDR = `CACHE_CFG_WAY_EN;

    way_sel_t way_en_q;
    logic     way_en_wr;

    assign way_en_wr = cfg_we && (cfg_addr == WAY_EN_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            way_en_q <= '1;  // All ways usable out of reset
        end else if (way_en_wr) begin
            way_en_q <= cfg_wdata[CACHE_WAYS-1:0];
        end
    end

    always_comb begin
        case (cfg_addr)
            WAY_EN_ADDR: cfg_rdata = word_t'(way_en_q);
            default:     cfg_rdata = '0;  // Unmapped
        endcase
    end

    assign way_en = way_en_q;

endmodule

// File: hw/way_lookup.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module way_lookup (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              alloc,
    input  cache_pkg::index_t                                 index,
    input  cache_pkg::tag_t                                   req_tag,
    input  cache_pkg::way_meta_t [cache_pkg::CACHE_WAYS-1:0]  set_meta,
    input  cache_pkg::way_sel_t                               way_en,
    output logic                                              hit,
    output cache_pkg::way_sel_t                               hit_way,
    output cache_pkg::way_sel_t                               victim_way
);
    import cache_pkg::*;

    localparam int SETS     = 1 << `CACHE_INDEX_BITS;
    localparam int PTR_BITS = $clog2(CACHE_WAYS);

    logic [PTR_BITS-1:0] rr_ptr [SETS];
    logic [PTR_BITS-1:0] rr_idx;
    logic [PTR_BITS-1:0] cand;
    way_sel_t            invalid_ways;
    logic                found;

    always_comb begin
        for (int w = 0; w < CACHE_WAYS; w++) begin
            hit_way[w]      = way_en[w] && (set_meta[w].state != ST_I) &&
                              (set_meta[w].tag == req_tag);
            invalid_ways[w] = way_en[w] && (set_meta[w].state == ST_I);
        end
    end

    assign hit = |hit_way;

    // Lowest free way first, else round robin from the set pointer
    always_comb begin
        victim_way = '0;
        rr_idx     = rr_ptr[index];
        cand       = '0;
        found      = 1'b0;
        for (int w = 0; w < CACHE_WAYS; w++) begin
            if (!found && invalid_ways[w]) begin
                victim_way[w] = 1'b1;
                found         = 1'b1;
            end
        end
        for (int k = 0; k < CACHE_WAYS; k++) begin
            cand = rr_ptr[index] + PTR_BITS'(k);  // Wraps
            if (!found && way_en[cand]) begin
                victim_way[cand] = 1'b1;
                rr_idx           = cand;
                found            = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (alloc && (invalid_ways == '0)) begin
            rr_ptr[index] <= rr_idx + 1'b1;  // Step past the replaced way
        end
    end

    // Duplicate tags in a set would mean the fill path broke
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_way));

endmodule

// File: hw/store_merge.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module store_merge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::line_t        line_in,
    input  cache_pkg::offset_t      offset,
    input  cache_pkg::access_size_e size,
    input  cache_pkg::word_t        wdata,
    output cache_pkg::line_t        line_out,
    output cache_pkg::word_t        old_value
);
    import cache_pkg::*;

    logic [`CACHE_OFFSET_BITS+2:0] bit_pos;
    word_t                         size_mask;
    line_t                         shifted;
    line_t                         wmask;
    line_t                         wline;

    always_comb begin
        case (size)
            SZ_BYTE: size_mask = 32'h0000_00ff;
            SZ_HALF: size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    assign bit_pos   = {offset, 3'b000};  // Byte offset in bits
    assign shifted   = line_in >> bit_pos;
    assign old_value = shifted[31:0] & size_mask;

    assign wmask    = line_t'(size_mask) << bit_pos;
    assign wline    = line_t'(wdata & size_mask) << bit_pos;
    assign line_out = (line_in & ~wmask) | (wline & wmask);

    // Accesses never straddle their natural boundary
    assert property (@(posedge clk) disable iff (!rst_n)
        (size == SZ_BYTE) ||
        ((size == SZ_HALF) && !offset[0]) ||
        ((size == SZ_WORD) && (offset[1:0] == 2'b00)));

endmodule

// File: hw/tag_next_state.sv
`timescale 1ns/1ns

module tag_next_state (
    input  cache_pkg::way_meta_t [cache_pkg::CACHE_WAYS-1:0] cur_meta,
    input  cache_pkg::tag_t                                  tag_in,
    input  cache_pkg::line_state_e                           state_in,
    input  cache_pkg::way_sel_t                              sel_way,
    output cache_pkg::way_meta_t [cache_pkg::CACHE_WAYS-1:0] next_meta
);
    import cache_pkg::*;

    logic sel_ok;

    assign sel_ok = $onehot(sel_way);

    always_comb begin
        next_meta = cur_meta;
        if (sel_ok) begin
            for (int w = 0; w < CACHE_WAYS; w++) begin
                if (sel_way[w]) begin
                    next_meta[w].tag   = tag_in;
                    next_meta[w].state = state_in;
                end
            end
        end
    end

endmodule

// File: hw/data_next_state.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module data_next_state (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  cache_pkg::line_t [cache_pkg::CACHE_WAYS-1:0] cur_lines,
    input  cache_pkg::cache_req_t                        req,
    input  cache_pkg::way_sel_t                          sel_way,
    output cache_pkg::line_t [cache_pkg::CACHE_WAYS-1:0] next_lines,
    output cache_pkg::word_t                             rdata,
    output cache_pkg::word_t                             rewind_data,
    output cache_pkg::line_t                             evict_line
);
    import cache_pkg::*;

    line_t   sel_line;
    line_t   merged_line;
    word_t   old_value;
    offset_t offset;
    logic    sel_ok;

    assign offset = req.addr[`CACHE_OFFSET_BITS-1:0];
    assign sel_ok = req.valid && $onehot(sel_way);

    always_comb begin
        sel_line = '0;
        for (int w = 0; w < CACHE_WAYS; w++) begin
            if (sel_way[w]) begin
                sel_line = cur_lines[w];
            end
        end
    end

    store_merge u_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .line_in   (sel_line),
        .offset    (offset),
        .size      (req.size),
        .wdata     (req.wdata),
        .line_out  (merged_line),
        .old_value (old_value)
    );

    always_comb begin
        next_lines  = cur_lines;
        rdata       = '0;
        rewind_data = '0;
        if (sel_ok) begin
            case (req.op)
                LD: rdata = old_value;
                ST: begin
                    rewind_data = old_value;  // Old bytes for a later undo
                    for (int w = 0; w < CACHE_WAYS; w++) begin
                        if (sel_way[w]) begin
                            next_lines[w] = merged_line;
                        end
                    end
                end
                WR: begin
                    for (int w = 0; w < CACHE_WAYS; w++) begin
                        if (sel_way[w]) begin
                            next_lines[w] = req.fill_line;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Whether it is really written back is decided by the line state
    assign evict_line = sel_line;

endmodule

// File: hw/cache_set_top.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_set_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cache_pkg::cache_req_t           req,
    output cache_pkg::cache_resp_t          resp,
    output cache_pkg::evict_t               evict,
    input  logic                            cfg_we,
    input  logic [`CACHE_CFG_ADDR_BITS-1:0] cfg_addr,
    input  cache_pkg::word_t                cfg_wdata,
    output cache_pkg::word_t                cfg_rdata
);
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_BITS;

    way_meta_t [CACHE_WAYS-1:0] meta_q  [SETS];
    line_t     [CACHE_WAYS-1:0] lines_q [SETS];

    way_meta_t [CACHE_WAYS-1:0] set_meta;
    way_meta_t [CACHE_WAYS-1:0] next_meta;
    line_t     [CACHE_WAYS-1:0] set_lines;
    line_t     [CACHE_WAYS-1:0] next_lines;

    tag_t        req_tag;
    index_t      index;
    way_sel_t    way_en;
    logic        hit;
    way_sel_t    hit_way;
    way_sel_t    victim_way;
    way_sel_t    sel_way;
    way_sel_t    meta_sel;
    logic        is_ld;
    logic        is_st;
    logic        is_wr;
    logic        alloc;
    logic        dirty_evict;
    line_state_e state_in;
    way_meta_t   sel_meta;
    word_t       rdata;
    word_t       rewind_data;
    line_t       evict_line;

    assign req_tag   = req.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign index     = req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign set_meta  = meta_q[index];
    assign set_lines = lines_q[index];

    assign is_ld = req.valid && (req.op == LD);
    assign is_st = req.valid && (req.op == ST);
    assign is_wr = req.valid && (req.op == WR);
    assign alloc = is_wr && !hit && (way_en != '0);  // Fill into a victim

    always_comb begin
        sel_way = '0;
        if ((is_ld || is_st) && hit) begin
            sel_way = hit_way;
        end else if (is_wr) begin
            sel_way = hit ? hit_way : victim_way;  // Zero when mask is empty
        end
    end

    assign meta_sel = (is_st || is_wr) ? sel_way : '0;  // LD leaves state alone
    assign state_in = is_wr ? ST_S : ST_M;

    always_comb begin
        sel_meta = '0;
        for (int w = 0; w < CACHE_WAYS; w++) begin
            if (sel_way[w]) begin
                sel_meta = set_meta[w];
            end
        end
    end

    assign dirty_evict = is_wr && (sel_way != '0) && (sel_meta.state == ST_M);

    cache_cfg_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .way_en    (way_en)
    );

    way_lookup u_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .index      (index),
        .req_tag    (req_tag),
        .set_meta   (set_meta),
        .way_en     (way_en),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    tag_next_state u_tag_ns (
        .cur_meta  (set_meta),
        .tag_in    (req_tag),
        .state_in  (state_in),
        .sel_way   (meta_sel),
        .next_meta (next_meta)
    );

    data_next_state u_data_ns (
        .clk         (clk),
        .rst_n       (rst_n),
        .cur_lines   (set_lines),
        .req         (req),
        .sel_way     (sel_way),
        .next_lines  (next_lines),
        .rdata       (rdata),
        .rewind_data (rewind_data),
        .evict_line  (evict_line)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                meta_q[s] <= '0;  // All ways ST_I
            end
        end else if (req.valid) begin
            meta_q[index] <= next_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            lines_q[index] <= next_lines;
        end
    end

    always_ff @(posedge clk) begin
        resp.rdata       <= rdata;
        resp.rewind_data <= rewind_data;
        evict.addr       <= {sel_meta.tag, index, {`CACHE_OFFSET_BITS{1'b0}}};
        evict.line       <= evict_line;
        if (!rst_n) begin
            resp.valid  <= 1'b0;
            resp.hit    <= 1'b0;
            evict.valid <= 1'b0;
        end else begin
            resp.valid  <= req.valid;
            resp.hit    <= req.valid && hit && (is_ld || is_st || is_wr);
            evict.valid <= dirty_evict;
        end
    end

    // Every eviction rides on a response
    assert property (@(posedge clk) disable iff (!rst_n) evict.valid |-> resp.valid);

endmodule

// File: tests/tb_cache_checks.svh
`ifndef TB_CACHE_CHECKS_SVH
`define TB_CACHE_CHECKS_SVH

task automatic check_resp(input cache_resp_t got, input cache_resp_t exp);
    if (got !== exp) begin
        $display("ERROR resp got valid %h hit %h rdata %h rewind_data %h",
                 got.valid, got.hit, got.rdata, got.rewind_data);
        $display("ERROR resp expected valid %h hit %h rdata %h rewind_data %h",
                 exp.valid, exp.hit, exp.rdata, exp.rewind_data);
        stop_with_failure();
    end
endtask

task automatic check_evict(input evict_t got, input evict_t exp);
    logic bad;
    bad = (got.valid !== exp.valid);
    if (exp.valid) begin  // Payload only when valid
        bad = bad || (got.addr !== exp.addr) || (got.line !== exp.line);
    end
    if (bad) begin
        $display("ERROR evict got valid %h addr %h line %h",
                 got.valid, got.addr, got.line);
        $display("ERROR evict expected valid %h addr %h line %h",
                 exp.valid, exp.addr, exp.line);
        stop_with_failure();
    end
endtask

task automatic check_cfg(input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("ERROR cfg_rdata got %h expected %h", got, exp);
        stop_with_failure();
    end
endtask

`endif

// File: tests/tb_cache_set.sv
`timescale 1ns/1ns
`include "cache_defines.svh"

module tb_cache_set;
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_BITS;

    typedef enum logic [1:0] {
        DO_REQ,
        DO_CFG_WR,
        DO_CFG_RD
    } step_kind_e;

    typedef struct packed {
        step_kind_e   kind;
        cache_op_e    op;
        addr_t        addr;   // Config steps use the low bits
        access_size_e size;
        word_t        value;  // Config write data or expected read-back
        logic         hit;
        logic         evict;
    } step_t;

    logic                            clk;
    logic                            rst_n;
    cache_req_t                      req;
    cache_resp_t                     resp;
    evict_t                          evict;
    logic                            cfg_we;
    logic [`CACHE_CFG_ADDR_BITS-1:0] cfg_addr;
    word_t                           cfg_wdata;
    word_t                           cfg_rdata;

    integer seed;
    step_t  steps [$];

    // Reference model of the arrays
    tag_t        m_tag   [SETS][CACHE_WAYS];
    line_state_e m_state [SETS][CACHE_WAYS];
    line_t       m_line  [SETS][CACHE_WAYS];
    int          m_ptr   [SETS];
    way_sel_t    m_mask;

    cache_set_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .resp      (resp),
        .evict     (evict),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    `include "tb_cache_checks.svh"

    task automatic add_request(input cache_op_e op, input tag_t tag, input int set,
                               input int off, input access_size_e size,
                               input int hit, input int ev);
        step_t s;
        s       = '0;
        s.kind  = DO_REQ;
        s.op    = op;
        s.addr  = {tag, index_t'(set), offset_t'(off)};
        s.size  = size;
        s.hit   = (hit != 0);
        s.evict = (ev != 0);
        steps.push_back(s);
    endtask

    task automatic add_cfg(input step_kind_e kind, input int addr, input word_t value);
        step_t s;
        s       = '0;
        s.kind  = kind;
        s.addr  = addr_t'(addr);
        s.value = value;
        steps.push_back(s);
    endtask

    function automatic int size_bytes(input access_size_e size);
        case (size)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic word_t get_bytes(input line_t l, input int off, input int n);
        word_t v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = l[8*(off+b) +: 8];
        end
        return v;
    endfunction

    function automatic line_t put_bytes(input line_t l, input int off, input int n,
                                        input word_t d);
        line_t r;
        r = l;
        for (int b = 0; b < n; b++) begin
            r[8*(off+b) +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    // Invalid enabled way first, else next enabled way from the set pointer
    function automatic int choose_victim(input int set);
        int   w;
        int   way;
        logic found;
        way   = -1;
        found = 1'b0;
        for (int k = 0; k < CACHE_WAYS; k++) begin
            if (!found && m_mask[k] && (m_state[set][k] == ST_I)) begin
                way   = k;
                found = 1'b1;
            end
        end
        for (int k = 0; k < CACHE_WAYS; k++) begin
            w = (m_ptr[set] + k) % CACHE_WAYS;
            if (!found && m_mask[w]) begin
                way        = w;
                found      = 1'b1;
                m_ptr[set] = (w + 1) % CACHE_WAYS;
            end
        end
        return way;
    endfunction

    task automatic model_request(input cache_req_t r, output cache_resp_t er,
                                 output evict_t ee);
        tag_t tag;
        int   set;
        int   off;
        int   n;
        int   hw;
        int   vw;
        tag      = r.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
        set      = int'(r.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS]);
        off      = int'(r.addr[`CACHE_OFFSET_BITS-1:0]);
        n        = size_bytes(r.size);
        er       = '0;
        ee       = '0;
        er.valid = 1'b1;
        hw       = -1;
        for (int w = 0; w < CACHE_WAYS; w++) begin
            if (m_mask[w] && (m_state[set][w] != ST_I) && (m_tag[set][w] == tag)) begin
                hw = w;
            end
        end
        er.hit = (hw >= 0);
        case (r.op)
            LD: begin
                if (hw >= 0) begin
                    er.rdata = get_bytes(m_line[set][hw], off, n);
                end
            end
            ST: begin
                if (hw >= 0) begin
                    er.rewind_data   = get_bytes(m_line[set][hw], off, n);
                    m_line[set][hw]  = put_bytes(m_line[set][hw], off, n, r.wdata);
                    m_state[set][hw] = ST_M;
                end
            end
            WR: begin
                if (m_mask != '0) begin
                    vw = (hw >= 0) ? hw : choose_victim(set);
                    if (m_state[set][vw] == ST_M) begin  // Dirty data leaves
                        ee.valid = 1'b1;
                        ee.addr  = {m_tag[set][vw], index_t'(set), offset_t'(0)};
                        ee.line  = m_line[set][vw];
                    end
                    m_tag[set][vw]   = tag;
                    m_line[set][vw]  = r.fill_line;
                    m_state[set][vw] = ST_S;
                end
            end
            default: ;
        endcase
    endtask

    task automatic apply_request(input step_t s);
        cache_req_t  r;
        cache_resp_t exp_resp;
        evict_t      exp_evict;
        r           = '0;
        r.valid     = 1'b1;
        r.op        = s.op;
        r.addr      = s.addr;
        r.size      = s.size;
        r.wdata     = $random(seed);
        r.fill_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        model_request(r, exp_resp, exp_evict);
        if ((exp_resp.hit != s.hit) || (exp_evict.valid != s.evict)) begin
            $display("Stimulus table and reference model disagree at address %h", s.addr);
            stop_with_failure();
        end
        req = r;
        @(posedge clk);
        #2;
        req = '0;  // Single-cycle strobe
        if (!resp.valid) begin
            $display("No response one cycle after the request at address %h", s.addr);
            stop_with_failure();
        end
        check_resp(resp, exp_resp);
        check_evict(evict, exp_evict);
    endtask

    task automatic write_cfg(input step_t s);
        cfg_we    = 1'b1;
        cfg_addr  = s.addr[`CACHE_CFG_ADDR_BITS-1:0];
        cfg_wdata = s.value;
        if (int'(s.addr) == `CACHE_CFG_WAY_EN) begin
            m_mask = s.value[CACHE_WAYS-1:0];
        end
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
        check_resp(resp, '0);  // No request in the last cycle
        check_evict(evict, '0);
    endtask

    task automatic read_cfg(input step_t s);
        cfg_addr = s.addr[`CACHE_CFG_ADDR_BITS-1:0];
        #1;
        check_cfg(cfg_rdata, s.value);
    endtask

    task automatic build_table();
        add_request(LD, 24'h0000A0, 3, 0, SZ_WORD, 0, 0);  // Empty after reset
        add_request(LD, 24'h123456, 7, 8, SZ_WORD, 0, 0);
        add_cfg(DO_CFG_RD, 0, 32'h0000_000f);
        add_cfg(DO_CFG_RD, 1, 32'h0000_0000);
        add_request(WR, 24'h0000A0, 3, 0, SZ_WORD, 0, 0);  // Ways 0 to 3 in order
        add_request(WR, 24'h0000A1, 3, 0, SZ_WORD, 0, 0);
        add_request(WR, 24'h0000A2, 3, 0, SZ_WORD, 0, 0);
        add_request(WR, 24'h0000A3, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A0, 3, 5, SZ_BYTE, 1, 0);
        add_request(LD, 24'h0000A1, 3, 6, SZ_HALF, 1, 0);
        add_request(LD, 24'h0000A2, 3, 12, SZ_WORD, 1, 0);
        add_request(LD, 24'h0000A3, 3, 15, SZ_BYTE, 1, 0);
        add_request(ST, 24'h0000A1, 3, 2, SZ_BYTE, 1, 0);
        add_request(LD, 24'h0000A1, 3, 0, SZ_WORD, 1, 0);
        add_request(ST, 24'h0000A3, 3, 6, SZ_HALF, 1, 0);
        add_request(LD, 24'h0000A3, 3, 4, SZ_WORD, 1, 0);
        add_request(ST, 24'h0000A0, 3, 8, SZ_WORD, 1, 0);
        add_request(LD, 24'h0000A0, 3, 8, SZ_WORD, 1, 0);
        add_request(ST, 24'h0000B0, 3, 0, SZ_WORD, 0, 0);  // Store misses
        add_request(ST, 24'h0000A0, 5, 4, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A2, 3, 0, SZ_WORD, 1, 0);
        add_request(WR, 24'h0000A4, 3, 0, SZ_WORD, 0, 1);  // Way 0 dirty
        add_request(WR, 24'h0000A5, 3, 0, SZ_WORD, 0, 1);  // Way 1 dirty
        add_request(WR, 24'h0000A6, 3, 0, SZ_WORD, 0, 0);  // Way 2 clean
        add_request(LD, 24'h0000A0, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A4, 3, 4, SZ_HALF, 1, 0);
        add_request(ST, 24'h0000A4, 3, 0, SZ_WORD, 1, 0);
        add_request(WR, 24'h0000A4, 3, 0, SZ_WORD, 1, 1);  // Refill over dirty data
        add_request(LD, 24'h0000A3, 3, 4, SZ_WORD, 1, 0);
        add_cfg(DO_CFG_WR, 0, 32'h0000_0003);
        add_cfg(DO_CFG_RD, 0, 32'h0000_0003);
        add_request(LD, 24'h0000A6, 3, 0, SZ_WORD, 0, 0);  // Held in disabled ways
        add_request(LD, 24'h0000A3, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A5, 3, 0, SZ_WORD, 1, 0);
        add_request(WR, 24'h0000A7, 3, 0, SZ_WORD, 0, 0);  // Pointer skips way 3
        add_request(WR, 24'h0000A8, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A5, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A7, 3, 0, SZ_WORD, 1, 0);
        add_cfg(DO_CFG_WR, 0, 32'h0000_0000);
        add_cfg(DO_CFG_RD, 0, 32'h0000_0000);
        add_request(WR, 24'h0000A9, 3, 0, SZ_WORD, 0, 0);  // Dropped
        add_request(LD, 24'h0000A7, 3, 0, SZ_WORD, 0, 0);
        add_cfg(DO_CFG_WR, 0, 32'h0000_0003);
        add_request(LD, 24'h0000A9, 3, 0, SZ_WORD, 0, 0);
        add_request(WR, 24'h0000A9, 3, 0, SZ_WORD, 0, 0);
        add_request(LD, 24'h0000A8, 3, 0, SZ_WORD, 1, 0);
        add_request(LD, 24'h0000A7, 3, 0, SZ_WORD, 0, 0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        seed      = 66110;
        m_mask    = '1;
        for (int s = 0; s < SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < CACHE_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_state[s][w] = ST_I;
                m_line[s][w]  = '0;
            end
        end
        build_table();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_resp(resp, '0);
        check_evict(evict, '0);
        foreach (steps[i]) begin
            case (steps[i].kind)
                DO_REQ:    apply_request(steps[i]);
                DO_CFG_WR: write_cfg(steps[i]);
                default:   read_cfg(steps[i]);
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: cache_set.f
+incdir+hw
+incdir+tests
hw/cache_pkg.sv
hw/cache_cfg_regs.sv
hw/way_lookup.sv
hw/store_merge.sv
hw/tag_next_state.sv
hw/data_next_state.sv
hw/cache_set_top.sv
tests/tb_cache_set.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_set \
    -f cache_set.f \
    -Mdir obj_dir -o sim_cache_set

./obj_dir/sim_cache_set > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
